//--- src/banked_mem_pkg.sv
package banked_mem_pkg;

  // request opcode carried on req_op_i
  typedef enum logic {
    op_read  = 1'b0, // fetch one wide word
    op_write = 1'b1  // store one wide word under byte strobes
  } req_op_e;

  // front end sequencing
  // a write skips st_capture since there is no bank data to collect
  typedef enum logic [1:0] {
    st_idle    = 2'd0, // ready for a new request
    st_issue   = 2'd1, // one-cycle strobe toward the translator
    st_capture = 2'd2, // registered bank data valid, latch it
    st_resp    = 2'd3  // hold response until the requester takes it
  } fe_state_e;

endpackage

//--- src/bank_port_if.sv
interface bank_port_if #(
  parameter int BANKS     = 4,  // number of narrow banks
  parameter int OUT_WIDTH = 16, // datum width per bank
  parameter int OUT_DEPTH = 64  // rows per bank
);

  localparam int OUT_WE   = OUT_WIDTH / 8;       // byte enables per bank
  localparam int OUT_ADDR = $clog2(OUT_DEPTH);   // row address bits

  // all buses packed with bank 0 in the low slice
  logic [BANKS-1:0]           en;     // one enable per bank
  logic [BANKS*OUT_WE-1:0]    we;     // byte write-enables
  logic [BANKS*OUT_ADDR-1:0]  addr;   // row address per bank
  logic [BANKS*OUT_WIDTH-1:0] wrdata; // write datum per bank
  logic [BANKS*OUT_WIDTH-1:0] rddata; // registered read datum per bank

  // translator side
  modport ctrl (
    output en, we, addr, wrdata,
    input  rddata
  );

  // bank row side
  modport mem (
    input  en, we, addr, wrdata,
    output rddata
  );

endinterface

//--- src/bram_bank.sv
module bram_bank #(
  parameter int OUT_WIDTH = 16, // datum width, whole bytes
  parameter int OUT_DEPTH = 64  // rows
) (
  input  logic                         clk_i,
  input  logic                         en_i,
  input  logic [OUT_WIDTH/8-1:0]       we_i,
  input  logic [$clog2(OUT_DEPTH)-1:0] addr_i,
  input  logic [OUT_WIDTH-1:0]         wrdata_i,
  output logic [OUT_WIDTH-1:0]         rddata_o
);

  localparam int OUT_WE = OUT_WIDTH / 8; // one write-enable per byte

  logic [OUT_WIDTH-1:0] mem_q [OUT_DEPTH]; // storage array

  // single port, registered output
  // read sees the old contents when the same row is written
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rddata_o <= mem_q[addr_i]; // read-before-write
      for (int b = 0; b < OUT_WE; b++) begin
        if (we_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wrdata_i[b*8 +: 8]; // byte lane update
        end
      end
    end
  end

endmodule

//--- src/bram_intrf_translator.sv
module bram_intrf_translator #(
  parameter int IN_WIDTH  = 32, // wide word width
  parameter int OUT_WIDTH = 16, // bank datum width
  parameter int BANKS     = 4,  // bank count, power of two
  parameter int OUT_DEPTH = 64  // rows per bank
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // wide BRAM controller style port
  input  logic                en_i,
  input  logic [IN_WIDTH/8-1:0] we_i,
  input  logic [$clog2(BANKS*OUT_DEPTH/(IN_WIDTH/OUT_WIDTH))-1:0] addr_i,
  input  logic [IN_WIDTH-1:0] wrdata_i,
  output logic [IN_WIDTH-1:0] rddata_o,
  // narrow bank side
  bank_port_if.ctrl           bank
);

  localparam int DPW       = IN_WIDTH / OUT_WIDTH;          // data packed per wide word
  localparam int INJ_BITS  = $clog2(DPW);                   // lane bits appended to address
  localparam int LOG_BANKS = $clog2(BANKS);
  localparam int BANK_BITS = (LOG_BANKS > 0) ? LOG_BANKS : 1; // keep select at least 1 bit
  localparam int OUT_ADDR  = $clog2(OUT_DEPTH);
  localparam int OUT_WE    = OUT_WIDTH / 8;
  localparam int ADDR_W    = $clog2(BANKS * OUT_DEPTH / DPW); // word address bits
  localparam int IDX_W     = ADDR_W + INJ_BITS;             // internal datum index bits

  logic [IDX_W-1:0]     lane_idx  [DPW]; // datum index per lane
  logic [BANK_BITS-1:0] lane_bank [DPW]; // target bank per lane
  logic [OUT_ADDR-1:0]  lane_row  [DPW]; // row within that bank
  logic [BANK_BITS-1:0] sel_q     [DPW]; // bank select remembered for the read return

  // index = word address * DPW + lane, lsb lane first
  for (genvar j = 0; j < DPW; j++) begin : g_lane_map
    assign lane_idx[j]  = (IDX_W'(addr_i) << INJ_BITS) | IDX_W'(j);
    assign lane_bank[j] = BANK_BITS'(lane_idx[j] & IDX_W'(BANKS - 1)); // low bits
    assign lane_row[j]  = OUT_ADDR'(lane_idx[j] >> LOG_BANKS);        // bits above
  end

  // strobe fan-out, purely combinational
  // with BANKS >= DPW the lanes of one word never share a bank
  always_comb begin
    bank.en     = '0;
    bank.we     = '0;
    bank.addr   = '0;
    bank.wrdata = '0;
    for (int j = 0; j < DPW; j++) begin
      bank.en[lane_bank[j]] = en_i; // only targeted banks fire
      bank.addr[lane_bank[j]*OUT_ADDR +: OUT_ADDR]     = lane_row[j];
      bank.wrdata[lane_bank[j]*OUT_WIDTH +: OUT_WIDTH] = wrdata_i[j*OUT_WIDTH +: OUT_WIDTH];
      if (en_i) begin
        bank.we[lane_bank[j]*OUT_WE +: OUT_WE] = we_i[j*OUT_WE +: OUT_WE]; // byte strobes
      end
    end
  end

  // bank read is one cycle late, so the select follows it by one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int j = 0; j < DPW; j++) begin
        sel_q[j] <= '0;
      end
    end else if (en_i) begin
      for (int j = 0; j < DPW; j++) begin
        sel_q[j] <= lane_bank[j]; // loaded on every enable, read or write
      end
    end
  end

  // rebuild the wide word from the bank outputs
  for (genvar j = 0; j < DPW; j++) begin : g_lane_rd
    assign rddata_o[j*OUT_WIDTH +: OUT_WIDTH] = bank.rddata[sel_q[j]*OUT_WIDTH +: OUT_WIDTH];
  end

endmodule

//--- src/mem_req_frontend.sv
module mem_req_frontend #(
  parameter int IN_WIDTH  = 32, // wide word width
  parameter int OUT_WIDTH = 16, // bank datum width
  parameter int BANKS     = 4,  // bank count
  parameter int OUT_DEPTH = 64  // rows per bank
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // request channel
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  banked_mem_pkg::req_op_e req_op_i,
  input  logic [$clog2(BANKS*OUT_DEPTH/(IN_WIDTH/OUT_WIDTH))-1:0] req_addr_i,
  input  logic [IN_WIDTH-1:0]     req_wdata_i,
  input  logic [IN_WIDTH/8-1:0]   req_wstrb_i,
  // response channel
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output logic [IN_WIDTH-1:0]     resp_rdata_o,
  // wide BRAM strobes
  output logic                    bram_en_o,
  output logic [IN_WIDTH/8-1:0]   bram_we_o,
  output logic [$clog2(BANKS*OUT_DEPTH/(IN_WIDTH/OUT_WIDTH))-1:0] bram_addr_o,
  output logic [IN_WIDTH-1:0]     bram_wrdata_o,
  input  logic [IN_WIDTH-1:0]     bram_rddata_i
);

  localparam int DPW    = IN_WIDTH / OUT_WIDTH;
  localparam int IN_WE  = IN_WIDTH / 8;
  localparam int ADDR_W = $clog2(BANKS * OUT_DEPTH / DPW);

  banked_mem_pkg::fe_state_e state_q, state_d;
  banked_mem_pkg::req_op_e   op_q;     // opcode of the request in flight

  logic [ADDR_W-1:0]   addr_q;  // captured word address
  logic [IN_WIDTH-1:0] wdata_q; // captured write word
  logic [IN_WE-1:0]    wstrb_q; // captured byte strobes
  logic [IN_WIDTH-1:0] rdata_q; // response word

  logic req_fire;  // request accepted this edge
  logic resp_fire; // response taken this edge
  logic is_write;

  assign req_ready_o  = (state_q == banked_mem_pkg::st_idle);
  assign resp_valid_o = (state_q == banked_mem_pkg::st_resp);
  assign req_fire     = req_valid_i & req_ready_o;
  assign resp_fire    = resp_valid_o & resp_ready_i;
  assign is_write     = (op_q == banked_mem_pkg::op_write);

  // next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      banked_mem_pkg::st_idle: begin
        if (req_fire) begin
          state_d = banked_mem_pkg::st_issue;
        end
      end
      banked_mem_pkg::st_issue: begin
        // writes need no capture cycle
        state_d = is_write ? banked_mem_pkg::st_resp : banked_mem_pkg::st_capture;
      end
      banked_mem_pkg::st_capture: state_d = banked_mem_pkg::st_resp;
      banked_mem_pkg::st_resp: begin
        if (resp_fire) begin
          state_d = banked_mem_pkg::st_idle; // ready again next cycle
        end
      end
      default: state_d = banked_mem_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= banked_mem_pkg::st_idle;
      op_q    <= banked_mem_pkg::op_read;
    end else begin
      state_q <= state_d;
      if (req_fire) begin
        op_q <= req_op_i;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      wstrb_q <= req_wstrb_i;
    end
    if (state_q == banked_mem_pkg::st_capture) begin
      rdata_q <= bram_rddata_i; // bank data valid this cycle
    end else if (state_q == banked_mem_pkg::st_issue && is_write) begin
      rdata_q <= '0; // write ack carries no data
    end
  end

  // strobes only live in st_issue, so stalls never touch the banks
  assign bram_en_o     = (state_q == banked_mem_pkg::st_issue);
  assign bram_we_o     = (bram_en_o && is_write) ? wstrb_q : '0;
  assign bram_addr_o   = addr_q;
  assign bram_wrdata_o = wdata_q;
  assign resp_rdata_o  = rdata_q; // stable while resp_valid_o waits

endmodule

//--- src/banked_mem_top.sv
module banked_mem_top #(
  parameter int IN_WIDTH  = 32, // wide word width
  parameter int OUT_WIDTH = 16, // bank datum width
  parameter int BANKS     = 4,  // bank count, power of two, at least data per word
  parameter int OUT_DEPTH = 64  // rows per bank
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // request channel
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  banked_mem_pkg::req_op_e req_op_i,
  input  logic [$clog2(BANKS*OUT_DEPTH/(IN_WIDTH/OUT_WIDTH))-1:0] req_addr_i,
  input  logic [IN_WIDTH-1:0]     req_wdata_i,
  input  logic [IN_WIDTH/8-1:0]   req_wstrb_i,
  // response channel
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output logic [IN_WIDTH-1:0]     resp_rdata_o
);

  localparam int DPW      = IN_WIDTH / OUT_WIDTH;
  localparam int IN_WE    = IN_WIDTH / 8;
  localparam int ADDR_W   = $clog2(BANKS * OUT_DEPTH / DPW);
  localparam int OUT_WE   = OUT_WIDTH / 8;
  localparam int OUT_ADDR = $clog2(OUT_DEPTH);

  // wide port between front end and translator
  logic                bram_en;
  logic [IN_WE-1:0]    bram_we;
  logic [ADDR_W-1:0]   bram_addr;
  logic [IN_WIDTH-1:0] bram_wrdata;
  logic [IN_WIDTH-1:0] bram_rddata;

  bank_port_if #(
    .BANKS     (BANKS),
    .OUT_WIDTH (OUT_WIDTH),
    .OUT_DEPTH (OUT_DEPTH)
  ) bank_if ();

  mem_req_frontend #(
    .IN_WIDTH  (IN_WIDTH),
    .OUT_WIDTH (OUT_WIDTH),
    .BANKS     (BANKS),
    .OUT_DEPTH (OUT_DEPTH)
  ) i_mem_req_frontend (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .req_wstrb_i   (req_wstrb_i),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_rdata_o  (resp_rdata_o),
    .bram_en_o     (bram_en),
    .bram_we_o     (bram_we),
    .bram_addr_o   (bram_addr),
    .bram_wrdata_o (bram_wrdata),
    .bram_rddata_i (bram_rddata)
  );

  bram_intrf_translator #(
    .IN_WIDTH  (IN_WIDTH),
    .OUT_WIDTH (OUT_WIDTH),
    .BANKS     (BANKS),
    .OUT_DEPTH (OUT_DEPTH)
  ) i_bram_intrf_translator (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .en_i     (bram_en),
    .we_i     (bram_we),
    .addr_i   (bram_addr),
    .wrdata_i (bram_wrdata),
    .rddata_o (bram_rddata),
    .bank     (bank_if)
  );

  // bank row, each bank takes its own slice of the bank buses
  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    bram_bank #(
      .OUT_WIDTH (OUT_WIDTH),
      .OUT_DEPTH (OUT_DEPTH)
    ) i_bram_bank (
      .clk_i    (clk_i),
      .en_i     (bank_if.en[b]),
      .we_i     (bank_if.we[b*OUT_WE +: OUT_WE]),
      .addr_i   (bank_if.addr[b*OUT_ADDR +: OUT_ADDR]),
      .wrdata_i (bank_if.wrdata[b*OUT_WIDTH +: OUT_WIDTH]),
      .rddata_o (bank_if.rddata[b*OUT_WIDTH +: OUT_WIDTH])
    );
  end

endmodule

//--- tests/tb_banked_mem_top.sv
module tb_banked_mem_top;

  timeunit 1ns;
  timeprecision 1ps;

  // defaults of the DUT, mirrored here for the reference model
  localparam int IN_WIDTH  = 32;
  localparam int OUT_WIDTH = 16;
  localparam int BANKS     = 4;
  localparam int OUT_DEPTH = 64;
  localparam int WORDS     = BANKS * OUT_DEPTH / (IN_WIDTH / OUT_WIDTH); // 128 words
  localparam int ADDR_W    = $clog2(WORDS);
  localparam int IN_WE     = IN_WIDTH / 8;
  localparam int TIMEOUT   = 100; // cycles per wait loop

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  banked_mem_pkg::req_op_e req_op_i;
  logic [ADDR_W-1:0]       req_addr_i;
  logic [IN_WIDTH-1:0]     req_wdata_i;
  logic [IN_WE-1:0]        req_wstrb_i;
  logic                    resp_valid_o;
  logic                    resp_ready_i;
  logic [IN_WIDTH-1:0]     resp_rdata_o;

  logic [7:0] ref_mem [WORDS*IN_WE]; // byte model of the whole word space

  integer seed;
  int     errors;      // failed checks plus timeouts
  int     checks;
  int     tests_pass;
  int     tests_fail;
  bit     timeout_hit; // later waits give up once set

  banked_mem_top i_banked_mem_top (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_wstrb_i  (req_wstrb_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i; // 10 ns period
  end

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  // expected word rebuilt from the byte model, lane 0 in the low bytes
  function automatic logic [IN_WIDTH-1:0] model_word(input logic [ADDR_W-1:0] a);
    logic [IN_WIDTH-1:0] w;
    for (int b = 0; b < IN_WE; b++) begin
      w[b*8 +: 8] = ref_mem[int'(a)*IN_WE + b];
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s expected %08h actual %08h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout: %s after %0d cycles at %0t", what, TIMEOUT, $time);
    timeout_hit = 1'b1;
    errors++;
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // present one request, wait for acceptance, then for resp_valid_o
  // lat counts cycles from the accepting cycle to the first valid cycle
  task automatic send_req(input banked_mem_pkg::req_op_e op, input logic [ADDR_W-1:0] a,
                          input logic [IN_WIDTH-1:0] wdata, input logic [IN_WE-1:0] wstrb,
                          output int lat);
    int cnt;
    lat = 0;
    if (timeout_hit) return;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = a;
    req_wdata_i = wdata;
    req_wstrb_i = wstrb;
    cnt = 0;
    while (!req_ready_o && cnt < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      cnt++;
    end
    if (!req_ready_o) begin
      req_valid_i = 1'b0;
      note_timeout("request was never accepted");
      return;
    end
    @(posedge clk_i); // accepted on this edge
    #1;
    req_valid_i = 1'b0;
    if (op == banked_mem_pkg::op_write) begin
      for (int b = 0; b < IN_WE; b++) begin
        if (wstrb[b]) ref_mem[int'(a)*IN_WE + b] = wdata[b*8 +: 8]; // strobed bytes only
      end
    end
    lat = 1;
    cnt = 0;
    while (!resp_valid_o && cnt < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      lat++;
      cnt++;
    end
    if (!resp_valid_o) note_timeout("no response after an accepted request");
  endtask

  // take the pending response, with random resp_ready_i stalls when asked
  task automatic take_resp(input bit stall, output logic [IN_WIDTH-1:0] data);
    logic [IN_WIDTH-1:0] held;
    logic [31:0]         r;
    int                  cnt;
    data = '0;
    if (timeout_hit) return;
    held = resp_rdata_o;
    r = rand_word();
    resp_ready_i = stall ? r[0] : 1'b1;
    cnt = 0;
    while (!resp_ready_i && cnt < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      cnt++;
      check_value("resp_valid_o", 32'd1, 32'(resp_valid_o)); // held while stalled
      check_value("resp_rdata_o", held, resp_rdata_o);
      check_value("req_ready_o", 32'd0, 32'(req_ready_o));
      r = rand_word();
      resp_ready_i = r[0];
    end
    if (!resp_ready_i) begin
      resp_ready_i = 1'b1;
      note_timeout("stall on resp_ready_i never released");
      return;
    end
    data = held;
    @(posedge clk_i); // response transfers here
    #1;
    check_value("req_ready_o", 32'd1, 32'(req_ready_o)); // ready again next cycle
    check_value("resp_valid_o", 32'd0, 32'(resp_valid_o));
  endtask

  task automatic do_write(input logic [ADDR_W-1:0] a, input logic [IN_WIDTH-1:0] wdata,
                          input logic [IN_WE-1:0] wstrb, input bit stall);
    int                  lat;
    logic [IN_WIDTH-1:0] ack_data;
    send_req(banked_mem_pkg::op_write, a, wdata, wstrb, lat);
    if (timeout_hit) return;
    check_value("write latency", 32'd2, 32'(lat)); // idle, issue, resp
    take_resp(stall, ack_data);
    check_value("resp_rdata_o", 32'd0, ack_data); // write ack has no data
  endtask

  task automatic do_read(input logic [ADDR_W-1:0] a, input bit stall,
                         output logic [IN_WIDTH-1:0] data);
    int lat;
    data = '0;
    send_req(banked_mem_pkg::op_read, a, rand_word(), '0, lat);
    if (timeout_hit) return;
    check_value("read latency", 32'd3, 32'(lat)); // idle, issue, capture, resp
    take_resp(stall, data);
    check_value("resp_rdata_o", model_word(a), data);
  endtask

  task automatic check_reset_state();
    int e0;
    e0 = errors;
    check_value("req_ready_o", 32'd1, 32'(req_ready_o));
    check_value("resp_valid_o", 32'd0, 32'(resp_valid_o));
    check_value("bank_if.en", 32'd0, 32'(i_banked_mem_top.bank_if.en)); // banks idle
    check_value("bank_if.we", 32'd0, 32'(i_banked_mem_top.bank_if.we));
    end_test("reset_state", e0);
  endtask

  task automatic write_read_back();
    logic [IN_WIDTH-1:0] wdata, rdata;
    int                  e0;
    e0 = errors;
    wdata = rand_word();
    do_write(7'd5, wdata, 4'hf, 1'b0);
    do_read(7'd5, 1'b0, rdata);
    check_value("resp_rdata_o", wdata, rdata); // straight against the written word
    end_test("write_read_back", e0);
  endtask

  task automatic byte_strobes();
    logic [IN_WIDTH-1:0] base, upd, rdata;
    int                  e0;
    e0 = errors;
    base = rand_word();
    upd  = rand_word();
    do_write(7'd9, base, 4'hf, 1'b0);
    do_write(7'd9, upd, 4'b0101, 1'b0); // bytes 0 and 2 only
    do_read(7'd9, 1'b0, rdata);
    check_value("resp_rdata_o", (base & 32'hff00ff00) | (upd & 32'h00ff00ff), rdata);
    do_write(7'd9, ~upd, 4'b1000, 1'b0); // top byte alone
    do_read(7'd9, 1'b0, rdata);
    end_test("byte_strobes", e0);
  endtask

  // every word gets written, so any aliasing between lanes or banks shows on read back
  task automatic interleave_fill();
    logic [31:0]         r;
    logic [IN_WIDTH-1:0] rdata;
    int                  e0;
    e0 = errors;
    for (int a = 0; a < WORDS; a++) begin
      do_write(ADDR_W'(a), rand_word(), 4'hf, 1'b0);
    end
    for (int a = 0; a < WORDS; a++) begin
      r = rand_word();
      do_write(ADDR_W'(a), rand_word(), r[4] ? 4'hf : r[3:0], 1'b0); // full or partial
    end
    for (int a = 0; a < WORDS; a++) begin
      do_read(ADDR_W'(a), 1'b0, rdata);
    end
    end_test("interleave_fill", e0);
  endtask

  task automatic back_pressure();
    logic [IN_WIDTH-1:0] held;
    int                  lat;
    int                  e0;
    e0 = errors;
    resp_ready_i = 1'b0;
    send_req(banked_mem_pkg::op_read, 7'd17, '0, '0, lat);
    if (!timeout_hit) begin
      check_value("read latency", 32'd3, 32'(lat));
      held = resp_rdata_o;
      check_value("resp_rdata_o", model_word(7'd17), held);
      repeat (6) begin
        @(posedge clk_i);
        #1;
        check_value("resp_valid_o", 32'd1, 32'(resp_valid_o));
        check_value("resp_rdata_o", held, resp_rdata_o);
        check_value("req_ready_o", 32'd0, 32'(req_ready_o));
        check_value("bank_if.en", 32'd0, 32'(i_banked_mem_top.bank_if.en)); // no strobes
      end
      resp_ready_i = 1'b1;
      @(posedge clk_i); // released, transfer on this edge
      #1;
      check_value("req_ready_o", 32'd1, 32'(req_ready_o));
      check_value("resp_valid_o", 32'd0, 32'(resp_valid_o));
    end
    resp_ready_i = 1'b1;
    end_test("back_pressure", e0);
  endtask

  task automatic mixed_traffic();
    logic [31:0]         r;
    logic [ADDR_W-1:0]   a;
    logic [IN_WIDTH-1:0] rdata;
    int                  e0;
    e0 = errors;
    for (int n = 0; n < 200 && !timeout_hit; n++) begin
      r = rand_word();
      a = r[ADDR_W+7:8];
      repeat (int'(r[1:0])) begin
        @(posedge clk_i); // idle gap, req_valid_i low
        #1;
      end
      if (r[2]) begin
        do_write(a, rand_word(), r[5] ? 4'hf : r[7:4], 1'b1);
      end else begin
        do_read(a, 1'b1, rdata); // compared to the model inside
      end
    end
    end_test("mixed_traffic", e0);
  endtask

  initial begin
    seed        = 32'hd0d3c382;
    errors      = 0;
    checks      = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    timeout_hit = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = banked_mem_pkg::op_read;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    req_wstrb_i  = '0;
    resp_ready_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    check_reset_state();
    write_read_back();
    byte_strobes();
    interleave_fill();
    back_pressure();
    mixed_traffic();

    $display("summary: %0d tests ok, %0d tests failed, %0d checks, %0d errors",
             tests_pass, tests_fail, checks, errors);
    if (errors == 0 && tests_fail == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- banked_mem_top.f
src/banked_mem_pkg.sv
src/bank_port_if.sv
src/bram_bank.sv
src/bram_intrf_translator.sv
src/mem_req_frontend.sv
src/banked_mem_top.sv
tests/tb_banked_mem_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the banked memory testbench with Verilator
# the log decides pass or fail, not the simulator exit status

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --assert -j 0 \
  --top-module tb_banked_mem_top \
  -f banked_mem_top.f \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run aborted"; exit 1; }

cat sim.log

grep -q "TESTBENCH PASSED" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
